// File: verilog.f
rtl/storePkg.sv
rtl/storeFuser.sv
rtl/evictBuffer.sv
rtl/loadForwarder.sv
rtl/storeBackend.sv
tb/storeChecker.sv
tb/tbStoreBackend.sv

// File: Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f verilog.f --top-module tbStoreBackend -o simv

run: compile
	@out="$$(./obj_dir/simv)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^SIMULATION PASSED$$"

clean:
	rm -rf obj_dir

// File: tb/tbStoreBackend.sv
module tbStoreBackend;

    localparam int numRows = 8;
    localparam logic [1:0] ackOk = 2'd0;
    localparam logic [1:0] ackFailOnce = 2'd1;
    localparam logic [1:0] stallOnce = 2'd2;

    typedef struct packed {
        logic [95:0] name;
        logic s0v;
        logic [31:0] s0a;
        logic [31:0] s0d;
        logic [3:0] s0m;
        logic s1v;
        logic [31:0] s1a;
        logic [31:0] s1d;
        logic [3:0] s1m;
        logic ldv;
        logic [31:0] lda;
        logic [1:0] react;
        logic [1:0] nExp;
        logic [31:0] e0a;
        logic [127:0] e0d;
        logic [15:0] e0m;
        logic e0mm;
        logic [31:0] e1a;
        logic [127:0] e1d;
        logic [15:0] e1m;
        logic e1mm;
        logic [31:0] fd;
        logic [3:0] fm;
        logic expStall;
    } rowT;

    rowT rows [numRows];
    rowT cur;

    logic clk;
    logic rst;
    logic [1:0] stValid;
    logic [31:0] stAddr [2];
    logic [31:0] stData [2];
    logic [3:0] stMask [2];
    logic [1:0] stStall;
    logic memValid;
    logic [1:0] memSlot;
    logic [3:0] memNonce;
    logic [31:0] memAddr;
    logic [127:0] memData;
    logic [15:0] memMask;
    logic memIsMmio;
    logic memStall;
    logic ackValid;
    logic [1:0] ackSlot;
    logic [3:0] ackNonce;
    logic ackFail;
    logic [1:0] ldValid;
    logic [31:0] ldAddr [2];
    logic [1:0] fwdValid;
    logic [31:0] fwdData [2];
    logic [3:0] fwdMask [2];
    logic busy;

    logic rowDone;
    int errCount;
    int issueCount;
    logic [1:0] react;
    bit reactUsed;
    int cycle;
    int dueQ [$];
    logic [1:0] slotQ [$];
    logic [3:0] nonceQ [$];
    bit failQ [$];

    storeBackend #(
        .numIn(2),
        .numEvicted(4),
        .numLoads(2)
    ) u_storeBackend (
        .clk(clk), .rst(rst),
        .stValid(stValid), .stAddr(stAddr), .stData(stData), .stMask(stMask),
        .stStall(stStall),
        .memValid(memValid), .memSlot(memSlot), .memNonce(memNonce), .memAddr(memAddr),
        .memData(memData), .memMask(memMask), .memIsMmio(memIsMmio), .memStall(memStall),
        .ackValid(ackValid), .ackSlot(ackSlot), .ackNonce(ackNonce), .ackFail(ackFail),
        .ldValid(ldValid), .ldAddr(ldAddr), .fwdValid(fwdValid), .fwdData(fwdData),
        .fwdMask(fwdMask), .busy(busy)
    );

    storeChecker u_storeChecker (
        .clk(clk), .rst(rst),
        .memValid(memValid), .memSlot(memSlot), .memNonce(memNonce), .memAddr(memAddr),
        .memData(memData), .memMask(memMask), .memIsMmio(memIsMmio),
        .fwdValid(fwdValid), .fwdData(fwdData), .fwdMask(fwdMask), .busy(busy),
        .stValid(stValid), .stStall(stStall), .rowDone(rowDone), .rowName(cur.name),
        .react(cur.react), .nExp(cur.nExp),
        .e0Addr(cur.e0a), .e0Data(cur.e0d), .e0Mask(cur.e0m), .e0Mmio(cur.e0mm),
        .e1Addr(cur.e1a), .e1Data(cur.e1d), .e1Mask(cur.e1m), .e1Mmio(cur.e1mm),
        .ldv(cur.ldv), .expFwdData(cur.fd), .expFwdMask(cur.fm), .expStall(cur.expStall),
        .errCount(errCount), .issueCount(issueCount)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // Expected lines worked out by hand from the line base and the word lane at addr bits 3:2
    task automatic loadTable();
        rows[0] = '{"single_word2", 1'b1, 32'h0000_1008, 32'hAABB_CCDD, 4'hF,
            1'b0, 32'h0, 32'h0, 4'h0, 1'b0, 32'h0, ackOk, 2'd1,
            32'h0000_1000, 128'h0000_0000_AABB_CCDD_0000_0000_0000_0000, 16'h0F00, 1'b0,
            32'h0, 128'h0, 16'h0, 1'b0, 32'h0, 4'h0, 1'b0};
        rows[1] = '{"merge_same  ", 1'b1, 32'h0000_2000, 32'h1122_3344, 4'hF,
            1'b1, 32'h0000_2000, 32'h5566_7788, 4'h3, 1'b1, 32'h0000_2000, ackOk, 2'd1,
            32'h0000_2000, 128'h0000_0000_0000_0000_0000_0000_1122_7788, 16'h000F, 1'b0,
            32'h0, 128'h0, 16'h0, 1'b0, 32'h1122_7788, 4'hF, 1'b0};
        rows[2] = '{"split_lines ", 1'b1, 32'h0000_3004, 32'hCAFE_F00D, 4'hF,
            1'b1, 32'h0000_3040, 32'h0BAD_BEEF, 4'hC, 1'b0, 32'h0, ackOk, 2'd2,
            32'h0000_3000, 128'h0000_0000_0000_0000_CAFE_F00D_0000_0000, 16'h00F0, 1'b0,
            32'h0000_3040, 128'h0000_0000_0000_0000_0000_0000_0BAD_0000, 16'h000C, 1'b0,
            32'h0, 4'h0, 1'b1};
        rows[3] = '{"load_miss   ", 1'b0, 32'h0, 32'h0, 4'h0,
            1'b0, 32'h0, 32'h0, 4'h0, 1'b1, 32'h0000_5004, ackOk, 2'd0,
            32'h0, 128'h0, 16'h0, 1'b0, 32'h0, 128'h0, 16'h0, 1'b0, 32'h0, 4'h0, 1'b0};
        rows[4] = '{"mmio_store  ", 1'b1, 32'hF000_0008, 32'h1234_5678, 4'hF,
            1'b0, 32'h0, 32'h0, 4'h0, 1'b1, 32'hF000_0008, ackOk, 2'd1,
            32'hF000_0008, 128'h0000_0000_0000_0000_0000_0000_1234_5678, 16'h000F, 1'b1,
            32'h0, 128'h0, 16'h0, 1'b0, 32'h0, 4'h0, 1'b0};
        rows[5] = '{"ack_fail    ", 1'b1, 32'h0000_6000, 32'hDEAD_BEEF, 4'hF,
            1'b0, 32'h0, 32'h0, 4'h0, 1'b0, 32'h0, ackFailOnce, 2'd1,
            32'h0000_6000, 128'h0000_0000_0000_0000_0000_0000_DEAD_BEEF, 16'h000F, 1'b0,
            32'h0, 128'h0, 16'h0, 1'b0, 32'h0, 4'h0, 1'b0};
        rows[6] = '{"mem_stall   ", 1'b1, 32'h0000_700C, 32'h0102_0304, 4'h6,
            1'b0, 32'h0, 32'h0, 4'h0, 1'b0, 32'h0, stallOnce, 2'd1,
            32'h0000_7000, 128'h0002_0300_0000_0000_0000_0000_0000_0000, 16'h6000, 1'b0,
            32'h0, 128'h0, 16'h0, 1'b0, 32'h0, 4'h0, 1'b0};
        rows[7] = '{"nonce_again ", 1'b1, 32'h0000_7004, 32'hA5A5_A5A5, 4'hF,
            1'b0, 32'h0, 32'h0, 4'h0, 1'b0, 32'h0, ackOk, 2'd1,
            32'h0000_7000, 128'h0000_0000_0000_0000_A5A5_A5A5_0000_0000, 16'h00F0, 1'b0,
            32'h0, 128'h0, 16'h0, 1'b0, 32'h0, 4'h0, 1'b0};
    endtask

    // Memory model acks three cycles after each write, or stalls or fails it once
    always @(negedge clk) begin
        cycle++;
        ackValid = 1'b0;
        memStall = 1'b0;
        if (dueQ.size() > 0 && dueQ[0] == cycle) begin
            void'(dueQ.pop_front());
            ackValid = 1'b1;
            ackSlot = slotQ.pop_front();
            ackNonce = nonceQ.pop_front();
            ackFail = failQ.pop_front();
        end
        if (memValid && !rst) begin
            if (react == stallOnce && !reactUsed) begin
                memStall = 1'b1;
                reactUsed = 1'b1;
            end else begin
                dueQ.push_back(cycle + 3);
                slotQ.push_back(memSlot);
                nonceQ.push_back(memNonce);
                failQ.push_back(react == ackFailOnce && !reactUsed);
                if (react == ackFailOnce) begin
                    reactUsed = 1'b1;
                end
            end
        end
    end

    task automatic applyRow(input rowT row);
        logic [31:0] pa [$];
        logic [31:0] pd [$];
        logic [3:0] pm [$];
        bit loadLeft;
        bit lateLoad;
        int idle;
        cur = row;
        react = row.react;
        reactUsed = 1'b0;
        loadLeft = row.ldv;
        lateLoad = 1'b0;
        idle = 0;
        if (row.s0v) begin
            pa.push_back(row.s0a);
            pd.push_back(row.s0d);
            pm.push_back(row.s0m);
        end
        if (row.s1v) begin
            pa.push_back(row.s1a);
            pd.push_back(row.s1d);
            pm.push_back(row.s1m);
        end
        while (idle < 3) begin
            @(negedge clk);
            stValid = '0;
            ldValid = '0;
            for (int i = 0; i < 2; i++) begin
                if (i < pa.size()) begin
                    stValid[i] = 1'b1;
                    stAddr[i] = pa[i];
                    stData[i] = pd[i];
                    stMask[i] = pm[i];
                end
            end
            // Port 1 looks a cycle later, once the fused line has moved into a slot
            if (lateLoad) begin
                ldValid[1] = 1'b1;
                ldAddr[1] = row.lda;
                lateLoad = 1'b0;
            end
            if (pa.size() == 0 && loadLeft) begin
                ldValid[0] = 1'b1;
                ldAddr[0] = row.lda;
                loadLeft = 1'b0;
                lateLoad = 1'b1;
            end
            #10;
            // A stalled store stays pending and moves up to the oldest position
            if (stValid[0] && !stStall[0]) begin
                void'(pa.pop_front());
                void'(pd.pop_front());
                void'(pm.pop_front());
                if (stValid[1] && !stStall[1]) begin
                    void'(pa.pop_front());
                    void'(pd.pop_front());
                    void'(pm.pop_front());
                end
            end
            if (pa.size() == 0 && !loadLeft && !lateLoad && !busy && ldValid == '0) begin
                idle++;
            end else begin
                idle = 0;
            end
        end
        @(negedge clk);
        rowDone = 1'b1;
        @(negedge clk);
        rowDone = 1'b0;
        #10;
    endtask

    initial begin
        repeat (numRows * 40) @(posedge clk);
        $display("timeout after %0d cycles: busy stayed high or a write never came",
            numRows * 40);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        rst = 1'b1;
        cycle = 0;
        stValid = '0;
        ldValid = '0;
        for (int i = 0; i < 2; i++) begin
            stAddr[i] = '0;
            stData[i] = '0;
            stMask[i] = '0;
            ldAddr[i] = '0;
        end
        memStall = 1'b0;
        ackValid = 1'b0;
        ackSlot = '0;
        ackNonce = '0;
        ackFail = 1'b0;
        rowDone = 1'b0;
        react = ackOk;
        reactUsed = 1'b0;
        loadTable();
        cur = rows[0];
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        #10;
        for (int r = 0; r < numRows; r++) begin
            applyRow(rows[r]);
        end
        $display("tests %0d, memory writes %0d, errors %0d", numRows, issueCount, errCount);
        if (errCount == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: tb/storeChecker.sv
module storeChecker (
    input  logic clk,
    input  logic rst,
    input  logic memValid,
    input  logic [1:0] memSlot,
    input  logic [3:0] memNonce,
    input  logic [31:0] memAddr,
    input  logic [127:0] memData,
    input  logic [15:0] memMask,
    input  logic memIsMmio,
    input  logic [1:0] fwdValid,
    input  logic [31:0] fwdData [2],
    input  logic [3:0] fwdMask [2],
    input  logic busy,
    input  logic [1:0] stValid,
    input  logic [1:0] stStall,
    input  logic rowDone,
    input  logic [95:0] rowName,
    input  logic [1:0] react,
    input  logic [1:0] nExp,
    input  logic [31:0] e0Addr,
    input  logic [127:0] e0Data,
    input  logic [15:0] e0Mask,
    input  logic e0Mmio,
    input  logic [31:0] e1Addr,
    input  logic [127:0] e1Data,
    input  logic [15:0] e1Mask,
    input  logic e1Mmio,
    input  logic ldv,
    input  logic [31:0] expFwdData,
    input  logic [3:0] expFwdMask,
    input  logic expStall,
    output int errCount,
    output int issueCount
);

    int seen;
    int reissues;
    int rowErrs;
    int k;
    bit stallSeen;
    bit [1:0] fwdSeen;
    logic [3:0] lastNonce [4];
    int slotExp [4];
    logic [3:0] issuedMask;

    // Only bytes under the mask carry meaning on the memory bus
    function automatic logic [127:0] byteBits(input logic [15:0] m);
        logic [127:0] r;
        for (int b = 0; b < 16; b++) begin
            r[b*8 +: 8] = {8{m[b]}};
        end
        return r;
    endfunction

    task automatic compareField(input string what, input logic [127:0] expV,
                                input logic [127:0] actV);
        if (expV !== actV) begin
            $display("FAILED %0s %0s expected %h actual %h", rowName, what, expV, actV);
            errCount++;
            rowErrs++;
        end
    endtask

    task automatic reportProblem(input string msg);
        $display("%0s: %0s", rowName, msg);
        errCount++;
        rowErrs++;
    endtask

    initial begin
        errCount = 0;
        issueCount = 0;
        seen = 0;
        reissues = 0;
        rowErrs = 0;
        stallSeen = 0;
        fwdSeen = '0;
        issuedMask = '0;
        for (int i = 0; i < 4; i++) begin
            lastNonce[i] = '0;
            slotExp[i] = 0;
        end
    end

    // Sample late in the low phase, after the driver and the memory model have settled
    always @(negedge clk) begin
        #20;
        if (!rst) begin
            if (memValid) begin
                issueCount++;
                if (!busy) begin
                    reportProblem("busy was low while a write was on the memory bus");
                end
                if (issuedMask[memSlot] && memNonce == lastNonce[memSlot]) begin
                    reissues++;
                    k = slotExp[memSlot];
                end else begin
                    compareField("memNonce", 128'(lastNonce[memSlot] + 4'd1), 128'(memNonce));
                    lastNonce[memSlot] = lastNonce[memSlot] + 4'd1;
                    issuedMask[memSlot] = 1'b1;
                    slotExp[memSlot] = seen;
                    k = seen;
                    seen++;
                end
                if (k >= int'(nExp)) begin
                    reportProblem("memory write that the test did not expect");
                end else if (k == 0) begin
                    compareField("memAddr", 128'(e0Addr), 128'(memAddr));
                    compareField("memData", e0Data & byteBits(e0Mask), memData & byteBits(e0Mask));
                    compareField("memMask", 128'(e0Mask), 128'(memMask));
                    compareField("memIsMmio", 128'(e0Mmio), 128'(memIsMmio));
                end else begin
                    compareField("memAddr", 128'(e1Addr), 128'(memAddr));
                    compareField("memData", e1Data & byteBits(e1Mask), memData & byteBits(e1Mask));
                    compareField("memMask", 128'(e1Mask), 128'(memMask));
                    compareField("memIsMmio", 128'(e1Mmio), 128'(memIsMmio));
                end
            end
            for (int h = 0; h < 2; h++) begin
                if (fwdValid[h]) begin
                    fwdSeen[h] = 1'b1;
                    compareField($sformatf("fwdData%0d", h), 128'(expFwdData),
                        128'(fwdData[h]));
                    compareField($sformatf("fwdMask%0d", h), 128'(expFwdMask),
                        128'(fwdMask[h]));
                end
            end
            if (stValid[1] && stStall[1]) begin
                stallSeen = 1'b1;
            end
            if (rowDone) begin
                if (seen != int'(nExp)) begin
                    reportProblem($sformatf("only %0d of %0d writes were issued", seen, nExp));
                end
                if (reissues != ((react != 2'd0) ? 1 : 0)) begin
                    reportProblem($sformatf("saw %0d reissues", reissues));
                end
                if (expStall && !stallSeen) begin
                    reportProblem("the younger store was never stalled");
                end
                if (ldv && fwdSeen != 2'b11) begin
                    reportProblem("a load port got no forwarding response");
                end
                if (rowErrs == 0) begin
                    $display("test %0s ok, %0d writes", rowName, seen);
                end else begin
                    $display("test %0s had %0d errors", rowName, rowErrs);
                end
                seen = 0;
                reissues = 0;
                rowErrs = 0;
                stallSeen = 0;
                fwdSeen = '0;
                issuedMask = '0;
            end
        end
    end

endmodule

// File: rtl/storeBackend.sv
module storeBackend #(
    parameter int numIn = 2,
    parameter int numEvicted = 4,
    parameter int numLoads = 2
) (
    input  logic clk,
    input  logic rst,

    input  logic [numIn-1:0] stValid,
    input  logic [31:0] stAddr [numIn],
    input  logic [storePkg::wordBits-1:0] stData [numIn],
    input  logic [storePkg::wordBytes-1:0] stMask [numIn],
    output logic [numIn-1:0] stStall,

    output logic memValid,
    output logic [$clog2(numEvicted)-1:0] memSlot,
    output logic [storePkg::nonceBits-1:0] memNonce,
    output logic [31:0] memAddr,
    output logic [storePkg::lineBits-1:0] memData,
    output logic [storePkg::lineBytes-1:0] memMask,
    output logic memIsMmio,
    input  logic memStall,

    input  logic ackValid,
    input  logic [$clog2(numEvicted)-1:0] ackSlot,
    input  logic [storePkg::nonceBits-1:0] ackNonce,
    input  logic ackFail,

    input  logic [numLoads-1:0] ldValid,
    input  logic [31:0] ldAddr [numLoads],
    output logic [numLoads-1:0] fwdValid,
    output logic [storePkg::wordBits-1:0] fwdData [numLoads],
    output logic [storePkg::wordBytes-1:0] fwdMask [numLoads],

    output logic busy
);

    logic fusedValid;
    logic [storePkg::wordAddrBits-1:0] fusedAddr;
    logic [storePkg::lineBits-1:0] fusedData;
    logic [storePkg::lineBytes-1:0] fusedMask;
    logic insertOk;

    logic [numEvicted-1:0] slotValid;
    logic [numEvicted*storePkg::wordAddrBits-1:0] slotAddr;
    logic [numEvicted*storePkg::lineBits-1:0] slotData;
    logic [numEvicted*storePkg::lineBytes-1:0] slotMask;
    logic anyValid;

    storeFuser #(
        .numIn(numIn)
    ) u_storeFuser (
        .clk(clk),
        .rst(rst),
        .stValid(stValid),
        .stAddr(stAddr),
        .stData(stData),
        .stMask(stMask),
        .stStall(stStall),
        .insertOk(insertOk),
        .fusedValid(fusedValid),
        .fusedAddr(fusedAddr),
        .fusedData(fusedData),
        .fusedMask(fusedMask)
    );

    evictBuffer #(
        .numEvicted(numEvicted)
    ) u_evictBuffer (
        .clk(clk),
        .rst(rst),
        .fusedValid(fusedValid),
        .fusedAddr(fusedAddr),
        .fusedData(fusedData),
        .fusedMask(fusedMask),
        .insertOk(insertOk),
        .memValid(memValid),
        .memSlot(memSlot),
        .memNonce(memNonce),
        .memAddr(memAddr),
        .memData(memData),
        .memMask(memMask),
        .memIsMmio(memIsMmio),
        .memStall(memStall),
        .ackValid(ackValid),
        .ackSlot(ackSlot),
        .ackNonce(ackNonce),
        .ackFail(ackFail),
        .slotValid(slotValid),
        .slotAddr(slotAddr),
        .slotData(slotData),
        .slotMask(slotMask),
        .anyValid(anyValid)
    );

    loadForwarder #(
        .numEvicted(numEvicted),
        .numLoads(numLoads)
    ) u_loadForwarder (
        .clk(clk),
        .rst(rst),
        .ldValid(ldValid),
        .ldAddr(ldAddr),
        .slotValid(slotValid),
        .slotAddr(slotAddr),
        .slotData(slotData),
        .slotMask(slotMask),
        .fusedValid(fusedValid),
        .fusedAddr(fusedAddr),
        .fusedData(fusedData),
        .fusedMask(fusedMask),
        .fwdValid(fwdValid),
        .fwdData(fwdData),
        .fwdMask(fwdMask)
    );

    // Anything still on its way to memory keeps the back end busy
    assign busy = (|stValid) || fusedValid || anyValid;

endmodule

// File: rtl/loadForwarder.sv
module loadForwarder #(
    parameter int numEvicted = 4,
    parameter int numLoads = 2
) (
    input  logic clk,
    input  logic rst,

    input  logic [numLoads-1:0] ldValid,
    input  logic [31:0] ldAddr [numLoads],

    input  logic [numEvicted-1:0] slotValid,
    input  logic [numEvicted*storePkg::wordAddrBits-1:0] slotAddr,
    input  logic [numEvicted*storePkg::lineBits-1:0] slotData,
    input  logic [numEvicted*storePkg::lineBytes-1:0] slotMask,

    input  logic fusedValid,
    input  logic [storePkg::wordAddrBits-1:0] fusedAddr,
    input  logic [storePkg::lineBits-1:0] fusedData,
    input  logic [storePkg::lineBytes-1:0] fusedMask,

    output logic [numLoads-1:0] fwdValid,
    output logic [storePkg::wordBits-1:0] fwdData [numLoads],
    output logic [storePkg::wordBytes-1:0] fwdMask [numLoads]
);

    localparam int numEntries = numEvicted + 1;
    localparam int addrW = storePkg::wordAddrBits;

    // Fused register takes the top index so it is searched last and wins
    logic [numEntries-1:0] entValid;
    logic [numEntries*addrW-1:0] entAddr;
    logic [numEntries*storePkg::lineBits-1:0] entData;
    logic [numEntries*storePkg::lineBytes-1:0] entMask;

    assign entValid = {fusedValid, slotValid};
    assign entAddr = {fusedAddr, slotAddr};
    assign entData = {fusedData, slotData};
    assign entMask = {fusedMask, slotMask};

    logic [storePkg::wordBits-1:0] lookupData [numLoads];
    logic [storePkg::wordBytes-1:0] lookupMask [numLoads];
    logic [addrW-1:0] curAddr;
    logic [storePkg::wordBits-1:0] curData;
    logic [storePkg::wordBytes-1:0] curMask;
    logic [storePkg::wordSelBits-1:0] lane;

    always_comb begin
        curAddr = '0;
        curData = '0;
        curMask = '0;
        lane = '0;
        for (int h = 0; h < numLoads; h++) begin
            lookupData[h] = '0;
            lookupMask[h] = '0;
            lane = ldAddr[h][3:2];
            for (int i = 0; i < numEntries; i++) begin
                curAddr = entAddr[i*addrW +: addrW];
                curData = entData[i*storePkg::lineBits + lane*storePkg::wordBits +:
                    storePkg::wordBits];
                curMask = entMask[i*storePkg::lineBytes + lane*storePkg::wordBytes +:
                    storePkg::wordBytes];
                // MMIO entries never forward
                if (entValid[i] && curAddr[addrW-1:storePkg::wordSelBits] == ldAddr[h][31:4] &&
                    !storePkg::isMmio({curAddr, 2'b00})) begin
                    for (int b = 0; b < storePkg::wordBytes; b++) begin
                        if (curMask[b]) begin
                            lookupData[h][b*8 +: 8] = curData[b*8 +: 8];
                        end
                    end
                    lookupMask[h] = lookupMask[h] | curMask;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            fwdValid <= '0;
        end else begin
            fwdValid <= ldValid;
        end
        for (int h = 0; h < numLoads; h++) begin
            if (ldValid[h]) begin
                fwdData[h] <= lookupData[h];
                fwdMask[h] <= lookupMask[h];
            end
        end
    end

endmodule

// File: rtl/evictBuffer.sv
module evictBuffer #(
    parameter int numEvicted = 4
) (
    input  logic clk,
    input  logic rst,

    input  logic fusedValid,
    input  logic [storePkg::wordAddrBits-1:0] fusedAddr,
    input  logic [storePkg::lineBits-1:0] fusedData,
    input  logic [storePkg::lineBytes-1:0] fusedMask,
    output logic insertOk,

    output logic memValid,
    output logic [$clog2(numEvicted)-1:0] memSlot,
    output logic [storePkg::nonceBits-1:0] memNonce,
    output logic [31:0] memAddr,
    output logic [storePkg::lineBits-1:0] memData,
    output logic [storePkg::lineBytes-1:0] memMask,
    output logic memIsMmio,
    input  logic memStall,

    input  logic ackValid,
    input  logic [$clog2(numEvicted)-1:0] ackSlot,
    input  logic [storePkg::nonceBits-1:0] ackNonce,
    input  logic ackFail,

    output logic [numEvicted-1:0] slotValid,
    output logic [numEvicted*storePkg::wordAddrBits-1:0] slotAddr,
    output logic [numEvicted*storePkg::lineBits-1:0] slotData,
    output logic [numEvicted*storePkg::lineBytes-1:0] slotMask,
    output logic anyValid
);

    localparam int slotBits = $clog2(numEvicted);
    localparam int addrW = storePkg::wordAddrBits;

    logic [numEvicted-1:0] issued;
    logic [storePkg::nonceBits-1:0] nonce [numEvicted];
    logic [addrW-1:0] addrQ [numEvicted];
    logic [storePkg::lineBits-1:0] dataQ [numEvicted];
    logic [storePkg::lineBytes-1:0] maskQ [numEvicted];

    logic ackValidQ;
    logic [slotBits-1:0] ackSlotQ;
    logic [storePkg::nonceBits-1:0] ackNonceQ;
    logic ackFailQ;

    logic fusedMmio;
    logic mmioBuffered;
    logic lineHit;
    logic freeFound;
    logic reissueOk;
    logic issueFree;
    logic [slotBits-1:0] hitIdx;
    logic [slotBits-1:0] freeIdx;
    logic [slotBits-1:0] insertIdx;
    logic [slotBits-1:0] reissueIdx;
    logic [storePkg::lineBits-1:0] mergeData;
    logic [storePkg::lineBytes-1:0] mergeMask;
    logic [storePkg::nonceBits-1:0] newNonce;

    assign fusedMmio = storePkg::isMmio({fusedAddr, 2'b00});

    // Scan downwards so the lowest matching slot wins
    always_comb begin
        mmioBuffered = 1'b0;
        lineHit = 1'b0;
        freeFound = 1'b0;
        reissueOk = 1'b0;
        hitIdx = '0;
        freeIdx = '0;
        reissueIdx = '0;
        for (int i = numEvicted - 1; i >= 0; i--) begin
            if (slotValid[i] && storePkg::isMmio({addrQ[i], 2'b00})) begin
                mmioBuffered = 1'b1;
            end
            if (slotValid[i] && !fusedMmio && addrQ[i] == fusedAddr) begin
                lineHit = 1'b1;
                hitIdx = slotBits'(i);
            end
            if (!slotValid[i]) begin
                freeFound = 1'b1;
                freeIdx = slotBits'(i);
            end
            if (slotValid[i] && !issued[i]) begin
                reissueOk = 1'b1;
                reissueIdx = slotBits'(i);
            end
        end
    end

    assign insertIdx = lineHit ? hitIdx : freeIdx;
    assign insertOk = fusedValid && !(mmioBuffered && fusedMmio) && (lineHit || freeFound);

    // Leave a gap after each write so memStall can be seen first
    assign issueFree = !memValid;

    // New bytes land over whatever the slot already holds
    always_comb begin
        mergeData = slotValid[insertIdx] ? dataQ[insertIdx] : '0;
        mergeMask = slotValid[insertIdx] ? maskQ[insertIdx] : '0;
        for (int b = 0; b < storePkg::lineBytes; b++) begin
            if (fusedMask[b]) begin
                mergeData[b*8 +: 8] = fusedData[b*8 +: 8];
            end
        end
        mergeMask = mergeMask | fusedMask;
    end

    assign newNonce = nonce[insertIdx] + 1'b1;

    always_ff @(posedge clk) begin
        if (rst) begin
            ackValidQ <= 1'b0;
        end else begin
            ackValidQ <= ackValid;
        end
        ackSlotQ <= ackSlot;
        ackNonceQ <= ackNonce;
        ackFailQ <= ackFail;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            slotValid <= '0;
            issued <= '0;
            memValid <= 1'b0;
            for (int i = 0; i < numEvicted; i++) begin
                nonce[i] <= '0;
            end
        end else begin
            memValid <= 1'b0;

            if (memValid && memStall) begin
                issued[memSlot] <= 1'b0;
            end

            // Stale nonces fall through untouched
            if (ackValidQ && slotValid[ackSlotQ] && ackNonceQ == nonce[ackSlotQ]) begin
                issued[ackSlotQ] <= 1'b0;
                if (!ackFailQ) begin
                    slotValid[ackSlotQ] <= 1'b0;
                end
            end

            if (issueFree && reissueOk) begin
                issued[reissueIdx] <= 1'b1;
                memValid <= 1'b1;
                memSlot <= reissueIdx;
                memNonce <= nonce[reissueIdx];
                memAddr <= {addrQ[reissueIdx], 2'b00};
                memData <= dataQ[reissueIdx];
                memMask <= maskQ[reissueIdx];
                memIsMmio <= storePkg::isMmio({addrQ[reissueIdx], 2'b00});
            end

            if (insertOk) begin
                slotValid[insertIdx] <= 1'b1;
                issued[insertIdx] <= 1'b0;
                nonce[insertIdx] <= newNonce;
                addrQ[insertIdx] <= fusedAddr;
                dataQ[insertIdx] <= mergeData;
                maskQ[insertIdx] <= mergeMask;
                if (issueFree && !reissueOk) begin
                    issued[insertIdx] <= 1'b1;
                    memValid <= 1'b1;
                    memSlot <= insertIdx;
                    memNonce <= newNonce;
                    memAddr <= {fusedAddr, 2'b00};
                    memData <= mergeData;
                    memMask <= mergeMask;
                    memIsMmio <= fusedMmio;
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < numEvicted; i++) begin
            slotAddr[i*addrW +: addrW] = addrQ[i];
            slotData[i*storePkg::lineBits +: storePkg::lineBits] = dataQ[i];
            slotMask[i*storePkg::lineBytes +: storePkg::lineBytes] = maskQ[i];
        end
    end

    assign anyValid = |slotValid;

    // The slot on the bus stays buffered for the whole pulse
    memPulse: assert property (@(posedge clk) disable iff (rst)
        memValid |-> slotValid[memSlot] ##1 !memValid);

    // An insert lands in a free slot or in the one holding the same line
    insertHasEntry: assert property (@(posedge clk) disable iff (rst)
        insertOk |-> fusedValid && (!slotValid[insertIdx] || addrQ[insertIdx] == fusedAddr));

endmodule

// File: rtl/storeFuser.sv
module storeFuser #(
    parameter int numIn = 2
) (
    input  logic clk,
    input  logic rst,

    input  logic [numIn-1:0] stValid,
    input  logic [31:0] stAddr [numIn],
    input  logic [storePkg::wordBits-1:0] stData [numIn],
    input  logic [storePkg::wordBytes-1:0] stMask [numIn],
    output logic [numIn-1:0] stStall,

    input  logic insertOk,
    output logic fusedValid,
    output logic [storePkg::wordAddrBits-1:0] fusedAddr,
    output logic [storePkg::lineBits-1:0] fusedData,
    output logic [storePkg::lineBytes-1:0] fusedMask
);

    logic nextValid;
    logic [storePkg::wordAddrBits-1:0] nextAddr;
    logic [storePkg::lineBits-1:0] nextData;
    logic [storePkg::lineBytes-1:0] nextMask;

    logic [storePkg::lineBits-1:0] baseData;
    logic [storePkg::lineBytes-1:0] baseMask;
    logic [storePkg::wordSelBits-1:0] baseLane;
    logic [storePkg::wordSelBits+1:0] byteIdx;
    logic takeNew;
    logic inOrder;

    // Register is free when empty or when the buffer takes it this cycle
    assign takeNew = (!fusedValid || insertOk) && stValid[0];

    always_comb begin
        nextValid = fusedValid && !insertOk;
        nextAddr = fusedAddr;
        nextData = fusedData;
        nextMask = fusedMask;
        stStall = '1;

        baseLane = stAddr[0][3:2];
        baseData = '0;
        baseData[storePkg::wordBits-1:0] = stData[0];
        baseMask = '0;
        baseMask[storePkg::wordBytes-1:0] = stMask[0];
        byteIdx = '0;
        inOrder = 1'b1;

        if (takeNew) begin
            stStall[0] = 1'b0;
            nextValid = 1'b1;

            if (storePkg::isMmio(stAddr[0])) begin
                // MMIO stays a single word at lane 0 under its word address
                nextAddr = stAddr[0][31:2];
                nextData = baseData;
                nextMask = baseMask;
            end else begin
                nextAddr = {stAddr[0][31:4], 2'b00};
                nextData = baseData << (baseLane * storePkg::wordBits);
                nextMask = baseMask << (baseLane * storePkg::wordBytes);

                for (int i = 1; i < numIn; i++) begin
                    // A younger store joins only while all older ones have joined
                    inOrder = inOrder && stValid[i] && !storePkg::isMmio(stAddr[i]) &&
                        (stAddr[i][31:4] == stAddr[0][31:4]);
                    if (inOrder) begin
                        stStall[i] = 1'b0;
                        for (int b = 0; b < storePkg::wordBytes; b++) begin
                            byteIdx = {stAddr[i][3:2], 2'(b)};
                            if (stMask[i][b]) begin
                                nextData[byteIdx*8 +: 8] = stData[i][b*8 +: 8];
                                nextMask[byteIdx] = 1'b1;
                            end
                        end
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            fusedValid <= 1'b0;
        end else begin
            fusedValid <= nextValid;
        end
        fusedAddr <= nextAddr;
        fusedData <= nextData;
        fusedMask <= nextMask;
    end

    fusedKnown: assert property (@(posedge clk) disable iff (rst)
        !$isunknown(fusedValid));

endmodule

// File: rtl/storePkg.sv
package storePkg;

    // Memory line geometry
    parameter int lineBytes = 16;
    parameter int lineBits = 128;

    // Line index is address bits 31:4
    parameter int lineIdxBits = 28;

    // Word within a line is address bits 3:2
    parameter int wordSelBits = 2;

    parameter int wordBytes = 4;
    parameter int wordBits = 32;

    // Word address as carried between the fuser, buffer and forwarder
    parameter int wordAddrBits = lineIdxBits + wordSelBits;

    parameter int nonceBits = 4;

    // Everything from here up is uncached device space
    parameter logic [31:0] mmioBase = 32'hF000_0000;

    function automatic logic isMmio(input logic [31:0] addr);
        return addr >= mmioBase;
    endfunction

endpackage
